/* hdl/spgd_pkg.sv */
package spgd_pkg;

	// ************************************************************
	// widths
	// ************************************************************
	localparam int dac_width = 14;
	localparam int adc_width = 12;
	localparam int gpio_width = 32;
	localparam int mode_width = 4;
	localparam int lfsr_width = 16;
	localparam int phase_width = 4;
	// zero bits above each 12-bit sample in the readback word
	localparam int adc_pad = (gpio_width - mode_width) / 2 - adc_width;

	// top nibble of the processor word
	typedef enum logic [mode_width-1:0]
	{
		system_off = 4'h0,
		off_adc_out = 4'h1,
		dac_follow_gpio = 4'h2,
		dac_follow_adc = 4'h3,
		pc_trig_lo_clk_lo = 4'h4,
		pc_trig_lo_clk_hi = 4'h5,
		pc_trig_hi_clk_lo = 4'h6,
		pc_trig_hi_clk_hi = 4'h7,
		spgd_adc = 4'h8,
		spgd_j = 4'h9,
		spgd_u = 4'ha,
		spgd_delta = 4'hb,
		spgd_dac = 4'hc,
		spgd_up = 4'hd,
		spgd_um = 4'he,
		spgd_new = 4'hf
	} mode_e;

	typedef enum logic [2:0]
	{
		sel_off = 3'd0,
		sel_spgd = 3'd1,
		sel_gpio = 3'd2,
		sel_adc = 3'd3,
		sel_pattern = 3'd4
	} dac_sel_e;

	// ************************************************************
	// optimiser
	// ************************************************************
	localparam int settle_cycles = 4;
	localparam int jp_phase = settle_cycles + 1;
	localparam int jm_phase = jp_phase + settle_cycles + 1;
	localparam int iter_last = jm_phase + 1;
	localparam logic [dac_width-1:0] delta_step = 14'd64;
	localparam logic [dac_width-1:0] u_init = 14'd8192;
	localparam logic [dac_width-1:0] dac_full = 14'd16383;
	localparam logic [lfsr_width-1:0] lfsr_seed = 16'hace1;
	localparam logic [lfsr_width-1:0] lfsr_taps = 16'hb400;

	// ************************************************************
	// words and pairs
	// ************************************************************
	typedef struct packed {mode_e mode; logic [dac_width-1:0] dac_b; logic [dac_width-1:0] dac_a;}
		ctrl_word_t;

	typedef struct packed {logic [dac_width-1:0] b; logic [dac_width-1:0] a;} dac_pair_t;
	typedef struct packed {logic [adc_width-1:0] b; logic [adc_width-1:0] a;} adc_pair_t;

	typedef struct packed
	{
		mode_e mode;
		logic [adc_pad-1:0] pad_b;
		logic [adc_width-1:0] b;
		logic [adc_pad-1:0] pad_a;
		logic [adc_width-1:0] a;
	} adc_view_t;

	typedef struct packed {mode_e mode; logic [dac_width-1:0] b; logic [dac_width-1:0] a;} dac_view_t;

	// sample pairs and code pairs share the readback word
	typedef union packed {adc_view_t adc_view; dac_view_t dac_view;} readback_u;

endpackage

/* hdl/gpio_box.sv */
`timescale 1ns/100ps

module gpio_box
(
	input spgd_pkg::ctrl_word_t ctrl,
	input spgd_pkg::adc_pair_t adc,
	input spgd_pkg::adc_pair_t j,
	input spgd_pkg::dac_pair_t dac,
	input spgd_pkg::dac_pair_t u,
	input spgd_pkg::dac_pair_t delta,
	input spgd_pkg::dac_pair_t up,
	input spgd_pkg::dac_pair_t um,
	input spgd_pkg::dac_pair_t new_u,
	output spgd_pkg::readback_u readback,
	output spgd_pkg::dac_sel_e dac_sel,
	output logic top_rst
);
	import spgd_pkg::*;

	always_comb
	begin
		readback = '0;
		readback.dac_view.mode = ctrl.mode;
		dac_sel = sel_spgd;
		top_rst = 1'b0;

		unique case (ctrl.mode)
			system_off:
			begin
				readback = '0;
				dac_sel = sel_off;
				top_rst = 1'b1;
			end
			off_adc_out, dac_follow_gpio, spgd_adc:
			begin
				readback.adc_view.b = adc.b;
				readback.adc_view.a = adc.a;
				if (ctrl.mode == off_adc_out)
					dac_sel = sel_off;
				else if (ctrl.mode == dac_follow_gpio)
					dac_sel = sel_gpio;
			end
			// mixed layout, dac a on top and the raw adc a below
			dac_follow_adc, pc_trig_lo_clk_lo, pc_trig_lo_clk_hi,
			pc_trig_hi_clk_lo, pc_trig_hi_clk_hi:
			begin
				readback.dac_view.b = dac.a;
				readback.dac_view.a = {{adc_pad{1'b0}}, adc.a};
				if (ctrl.mode == dac_follow_adc)
					dac_sel = sel_adc;
				else
					dac_sel = sel_pattern;
			end
			spgd_j:
			begin
				readback.adc_view.b = j.b;
				readback.adc_view.a = j.a;
			end
			spgd_u:
			begin
				readback.dac_view.b = u.b;
				readback.dac_view.a = u.a;
			end
			spgd_delta:
			begin
				readback.dac_view.b = delta.b;
				readback.dac_view.a = delta.a;
			end
			spgd_dac:
			begin
				readback.dac_view.b = dac.b;
				readback.dac_view.a = dac.a;
			end
			spgd_up:
			begin
				readback.dac_view.b = up.b;
				readback.dac_view.a = up.a;
			end
			spgd_um:
			begin
				readback.dac_view.b = um.b;
				readback.dac_view.a = um.a;
			end
			spgd_new:
			begin
				readback.dac_view.b = new_u.b;
				readback.dac_view.a = new_u.a;
			end
		endcase
	end

endmodule

/* hdl/spgd_core.sv */
`timescale 1ns/100ps

module spgd_core
(
	input logic clk,
	input logic rst,
	input logic top_rst,
	input spgd_pkg::dac_sel_e dac_sel,
	input spgd_pkg::adc_pair_t adc,
	output spgd_pkg::dac_pair_t drive,
	output spgd_pkg::dac_pair_t u,
	output spgd_pkg::dac_pair_t delta,
	output spgd_pkg::dac_pair_t up,
	output spgd_pkg::dac_pair_t um,
	output spgd_pkg::dac_pair_t new_u,
	output spgd_pkg::adc_pair_t j
);
	import spgd_pkg::*;

	logic run;
	logic [phase_width-1:0] phase;
	logic [lfsr_width-1:0] lfsr;
	logic [lfsr_width-1:0] lfsr_next;
	dac_pair_t delta_next;
	dac_pair_t up_next;
	dac_pair_t um_next;
	dac_pair_t pick;

	// base moved by one step, clipped to 0..dac_full
	function automatic logic [dac_width-1:0] step_sat
	(
		input logic [dac_width-1:0] base,
		input logic minus
	);
		logic [dac_width:0] wide;
		if (minus)
		begin
			wide = {1'b0, base} - {1'b0, delta_step};
			step_sat = wide[dac_width] ? '0 : wide[dac_width-1:0];
		end
		else
		begin
			wide = {1'b0, base} + {1'b0, delta_step};
			step_sat = wide[dac_width] ? dac_full : wide[dac_width-1:0];
		end
	endfunction

	// two's complement code of +/- delta_step
	function automatic logic [dac_width-1:0] step_signed(input logic minus);
		step_signed = minus ? ~delta_step + 1'b1 : delta_step;
	endfunction

	assign run = (dac_sel == sel_spgd);

	// ************************************************************
	// perturbation
	// ************************************************************
	always_comb
	begin
		// galois, right shift
		lfsr_next = lfsr >> 1;
		if (lfsr[0])
			lfsr_next = lfsr_next ^ lfsr_taps;

		// bit 0 -> channel a, bit 1 -> channel b, set means minus
		delta_next.a = step_signed(lfsr[0]);
		delta_next.b = step_signed(lfsr[1]);
		up_next.a = step_sat(u.a, lfsr[0]);
		up_next.b = step_sat(u.b, lfsr[1]);
		um_next.a = step_sat(u.a, !lfsr[0]);
		um_next.b = step_sat(u.b, !lfsr[1]);
	end

	// metric decision, ties keep u
	always_comb
	begin
		if (j.a > j.b)
			pick = up;
		else if (j.b > j.a)
			pick = um;
		else
			pick = u;
	end

	// plus side until jp is taken, then minus side
	always_comb
	begin
		if (phase == '0)
			drive = u;
		else if (phase <= jp_phase)
			drive = up;
		else
			drive = um;
	end

	// ************************************************************
	// iteration
	// ************************************************************
	always_ff @(posedge clk)
	begin
		if (rst || top_rst)
		begin
			phase <= '0;
			lfsr <= lfsr_seed;
			u <= {u_init, u_init};
			new_u <= {u_init, u_init};
			up <= {u_init, u_init};
			um <= {u_init, u_init};
			delta <= '0;
			j <= '0;
		end
		else if (!run)
			phase <= '0;
		else
		begin
			if (phase == iter_last)
				phase <= '0;
			else
				phase <= phase + 1'b1;

			case (phase)
				'0:
				begin
					lfsr <= lfsr_next;
					delta <= delta_next;
					up <= up_next;
					um <= um_next;
				end
				jp_phase:
					j.a <= adc.a;
				jm_phase:
					j.b <= adc.a;
				iter_last:
				begin
					// u moves with new_u so cycle 0 starts from the new point
					new_u <= pick;
					u <= pick;
				end
				default:
				begin
				end
			endcase
		end
	end

endmodule

/* hdl/dac_mux.sv */
`timescale 1ns/100ps

module dac_mux
(
	input logic clk,
	input logic rst,
	input spgd_pkg::dac_sel_e dac_sel,
	input spgd_pkg::ctrl_word_t ctrl,
	input spgd_pkg::adc_pair_t adc,
	input spgd_pkg::dac_pair_t drive,
	output spgd_pkg::dac_pair_t dac
);
	import spgd_pkg::*;

	logic trig;
	logic clk_level;

	// pattern levels come straight from the two low mode bits
	assign trig = ctrl.mode[1];
	assign clk_level = ctrl.mode[0];

	// ************************************************************
	// output register
	// ************************************************************
	always_ff @(posedge clk)
	begin
		if (rst)
			dac <= '0;
		else
		begin
			case (dac_sel)
				sel_spgd:
					dac <= drive;
				sel_gpio:
				begin
					dac.b <= ctrl.dac_b;
					dac.a <= ctrl.dac_a;
				end
				// 12-bit samples up to the 14-bit code range
				sel_adc:
				begin
					dac.b <= {adc.b, {(dac_width - adc_width){1'b0}}};
					dac.a <= {adc.a, {(dac_width - adc_width){1'b0}}};
				end
				sel_pattern:
				begin
					dac.a <= trig ? dac_full : '0;
					dac.b <= clk_level ? dac_full : '0;
				end
				default:
					dac <= '0;
			endcase
		end
	end

endmodule

/* hdl/spgd_top.sv */
`timescale 1ns/100ps

module spgd_top
(
	input logic clk,
	input logic rst,
	input spgd_pkg::ctrl_word_t ctrl,
	input spgd_pkg::adc_pair_t adc,
	output spgd_pkg::readback_u readback,
	output spgd_pkg::dac_pair_t dac,
	output logic top_rst
);
	import spgd_pkg::*;

	dac_sel_e dac_sel;
	dac_pair_t drive;
	dac_pair_t u;
	dac_pair_t delta;
	dac_pair_t up;
	dac_pair_t um;
	dac_pair_t new_u;
	adc_pair_t j;

	// mode decode and readback
	gpio_box gpio_box_i
	(
		.ctrl(ctrl),
		.adc(adc),
		.j(j),
		.dac(dac),
		.u(u),
		.delta(delta),
		.up(up),
		.um(um),
		.new_u(new_u),
		.readback(readback),
		.dac_sel(dac_sel),
		.top_rst(top_rst)
	);

	dac_mux dac_mux_i
	(
		.clk(clk),
		.rst(rst),
		.dac_sel(dac_sel),
		.ctrl(ctrl),
		.adc(adc),
		.drive(drive),
		.dac(dac)
	);

	// optimiser, held in reset while the system is off
	spgd_core spgd_core_i
	(
		.clk(clk),
		.rst(rst),
		.top_rst(top_rst),
		.dac_sel(dac_sel),
		.adc(adc),
		.drive(drive),
		.u(u),
		.delta(delta),
		.up(up),
		.um(um),
		.new_u(new_u),
		.j(j)
	);

endmodule

/* dv/spgd_top_tb.sv */
`timescale 1ns/100ps

module spgd_top_tb;
	import spgd_pkg::*;

	localparam int reset_cycles = 10;
	localparam int n_iterations = 400;
	localparam int n_detailed = 8;
	localparam int target_a = 5000;
	localparam int target_b = 11000;

	typedef struct packed
	{
		mode_e mode;
		dac_pair_t codes;
		adc_pair_t adc_in;
		int wait_cycles;
		logic check_dac;
		logic [gpio_width-1:0] exp_rb;
		dac_pair_t exp_dac;
		logic exp_top_rst;
	} entry_t;

	logic clk;
	logic rst;
	ctrl_word_t ctrl;
	adc_pair_t adc;
	readback_u readback;
	dac_pair_t dac;
	logic top_rst;

	entry_t table_q[$];
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int failed_tests = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	logic [adc_width-1:0] plant_a;
	logic [adc_width-1:0] applied_a;
	logic [lfsr_width-1:0] lfsr_m;
	dac_pair_t u_m;

	spgd_top spgd_top_i
	(
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.adc(adc),
		.readback(readback),
		.dac(dac),
		.top_rst(top_rst)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout, run stopped after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ************************************************************
	// expected words
	// ************************************************************
	function automatic logic [31:0] adc_word(input mode_e m, input adc_pair_t p);
		return {m, 2'b00, p.b, 2'b00, p.a};
	endfunction

	function automatic logic [31:0] code_word(input mode_e m, input dac_pair_t p);
		return {m, p.b, p.a};
	endfunction

	// dac a code above the raw adc a sample
	function automatic logic [31:0] mixed_word(input mode_e m, input logic [13:0] code,
		input logic [11:0] sample);
		return {m, code, 2'b00, sample};
	endfunction

	function automatic dac_pair_t pattern_dac(input logic trig_level, input logic clk_level);
		dac_pair_t p;
		p.a = trig_level ? dac_full : '0;
		p.b = clk_level ? dac_full : '0;
		return p;
	endfunction

	function automatic dac_pair_t scaled_adc(input adc_pair_t a);
		dac_pair_t p;
		p.a = 14'(int'(a.a) * 4);
		p.b = 14'(int'(a.b) * 4);
		return p;
	endfunction

	function automatic adc_pair_t rand_adc();
		adc_pair_t p;
		p.a = 12'($urandom);
		p.b = 12'($urandom);
		return p;
	endfunction

	function automatic dac_pair_t rand_codes();
		dac_pair_t p;
		p.a = 14'($urandom);
		p.b = 14'($urandom);
		return p;
	endfunction

	function automatic logic [13:0] clamp_code(input int v);
		if (v < 0)
			return '0;
		if (v > int'(dac_full))
			return dac_full;
		return 14'(v);
	endfunction

	function automatic int step_value(input logic minus);
		return minus ? -int'(delta_step) : int'(delta_step);
	endfunction

	function automatic logic [15:0] lfsr_step(input logic [15:0] cur);
		logic [15:0] nxt;
		nxt = cur >> 1;
		if (cur[0])
			nxt = nxt ^ lfsr_taps;
		return nxt;
	endfunction

	// metric peaks at dac a = 5000, dac b = 11000
	function automatic logic [11:0] plant_metric(input dac_pair_t d);
		int ea;
		int eb;
		int m;
		ea = int'(d.a) - target_a;
		eb = int'(d.b) - target_b;
		if (ea < 0)
			ea = -ea;
		if (eb < 0)
			eb = -eb;
		m = 4095 - (ea >> 2) - (eb >> 2);
		if (m < 0)
			m = 0;
		return 12'(m);
	endfunction

	function automatic entry_t make_entry(input mode_e m, input dac_pair_t codes,
		input adc_pair_t a, input int wait_n, input logic chk, input logic [31:0] rb,
		input dac_pair_t d, input logic trst);
		entry_t e;
		e.mode = m;
		e.codes = codes;
		e.adc_in = a;
		e.wait_cycles = wait_n;
		e.check_dac = chk;
		e.exp_rb = rb;
		e.exp_dac = d;
		e.exp_top_rst = trst;
		return e;
	endfunction

	task automatic build_table();
		mode_e pattern_modes[4];
		logic trig_hi[4];
		logic clk_hi[4];
		dac_pair_t mid;
		dac_pair_t codes;
		adc_pair_t a;
		pattern_modes = '{pc_trig_lo_clk_lo, pc_trig_lo_clk_hi, pc_trig_hi_clk_lo,
			pc_trig_hi_clk_hi};
		// trigger and clock levels as named by each pattern mode
		trig_hi = '{1'b0, 1'b0, 1'b1, 1'b1};
		clk_hi = '{1'b0, 1'b1, 1'b0, 1'b1};
		mid = {u_init, u_init};
		a = rand_adc();
		table_q.push_back(make_entry(system_off, '0, a, 1, 1'b1, '0, '0, 1'b1));
		table_q.push_back(make_entry(spgd_u, '0, a, 1, 1'b1, code_word(spgd_u, mid), mid, 1'b0));
		a = rand_adc();
		table_q.push_back(make_entry(off_adc_out, '0, a, 1, 1'b1, adc_word(off_adc_out, a), '0,
			1'b0));
		codes = rand_codes();
		a = rand_adc();
		table_q.push_back(make_entry(dac_follow_gpio, codes, a, 1, 1'b1,
			adc_word(dac_follow_gpio, a), codes, 1'b0));
		a = rand_adc();
		codes = scaled_adc(a);
		table_q.push_back(make_entry(dac_follow_adc, '0, a, 1, 1'b1,
			mixed_word(dac_follow_adc, codes.a, a.a), codes, 1'b0));
		foreach (pattern_modes[i])
		begin
			a = rand_adc();
			codes = pattern_dac(trig_hi[i], clk_hi[i]);
			table_q.push_back(make_entry(pattern_modes[i], '0, a, 1, 1'b1,
				mixed_word(pattern_modes[i], codes.a, a.a), codes, 1'b0));
		end
		// drive is still u in the first cycle of a run
		a = rand_adc();
		table_q.push_back(make_entry(spgd_adc, '0, a, 1, 1'b1, adc_word(spgd_adc, a), mid, 1'b0));
		table_q.push_back(make_entry(system_off, '0, a, 1, 1'b1, '0, '0, 1'b1));
		// jp and jm both taken from a steady adc a
		a = rand_adc();
		table_q.push_back(make_entry(spgd_j, '0, a, jm_phase + 1, 1'b0,
			adc_word(spgd_j, {a.a, a.a}), '0, 1'b0));
		table_q.push_back(make_entry(system_off, '0, a, 1, 1'b1, '0, '0, 1'b1));
	endtask

	// ************************************************************
	// drive and check
	// ************************************************************
	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic finish_test(input string label, input int start_errors);
		test_count++;
		if (error_count != start_errors)
		begin
			failed_tests++;
			$display("%s: %0d errors", label, error_count - start_errors);
		end
		else
			$display("%s: ok", label);
	endtask

	task automatic run_entry(input entry_t e);
		@(posedge clk);
		ctrl <= {e.mode, e.codes};
		adc <= e.adc_in;
		repeat (e.wait_cycles) @(posedge clk);
		@(negedge clk);
		check_field("readback", readback, e.exp_rb);
		if (e.check_dac)
			check_field("dac", {4'h0, dac}, {4'h0, e.exp_dac});
		check_field("top_rst", {31'b0, top_rst}, {31'b0, e.exp_top_rst});
	endtask

	// one clock in an optimiser mode with the plant closing the loop
	task automatic opt_cycle(input mode_e m);
		@(posedge clk);
		ctrl <= {m, {(2 * dac_width){1'b0}}};
		adc.a <= plant_a;
		applied_a = plant_a;
		@(negedge clk);
		plant_a = plant_metric(dac);
	endtask

	task automatic run_iteration();
		dac_pair_t delta_m;
		dac_pair_t up_m;
		dac_pair_t um_m;
		logic [adc_width-1:0] jp_m;
		logic [adc_width-1:0] jm_m;
		delta_m.a = 14'(step_value(lfsr_m[0]));
		delta_m.b = 14'(step_value(lfsr_m[1]));
		up_m.a = clamp_code(int'(u_m.a) + step_value(lfsr_m[0]));
		up_m.b = clamp_code(int'(u_m.b) + step_value(lfsr_m[1]));
		um_m.a = clamp_code(int'(u_m.a) - step_value(lfsr_m[0]));
		um_m.b = clamp_code(int'(u_m.b) - step_value(lfsr_m[1]));
		opt_cycle(spgd_new);
		check_field("new_u", readback, code_word(spgd_new, u_m));
		opt_cycle(spgd_u);
		check_field("u", readback, code_word(spgd_u, u_m));
		opt_cycle(spgd_delta);
		check_field("delta", readback, code_word(spgd_delta, delta_m));
		opt_cycle(spgd_up);
		check_field("up", readback, code_word(spgd_up, up_m));
		opt_cycle(spgd_um);
		check_field("um", readback, code_word(spgd_um, um_m));
		opt_cycle(spgd_dac);
		jp_m = applied_a;
		check_field("dac", {4'h0, dac}, {4'h0, up_m});
		check_field("readback", readback, code_word(spgd_dac, up_m));
		repeat (jm_phase - jp_phase - 1) opt_cycle(spgd_dac);
		opt_cycle(spgd_dac);
		jm_m = applied_a;
		check_field("dac", {4'h0, dac}, {4'h0, um_m});
		check_field("readback", readback, code_word(spgd_dac, um_m));
		opt_cycle(spgd_j);
		check_field("j", readback, adc_word(spgd_j, {jm_m, jp_m}));
		if (jp_m > jm_m)
			u_m = up_m;
		else if (jm_m > jp_m)
			u_m = um_m;
		lfsr_m = lfsr_step(lfsr_m);
	endtask

	task automatic check_convergence();
		int dist_a;
		int dist_b;
		opt_cycle(spgd_u);
		check_field("u", readback, code_word(spgd_u, u_m));
		dist_a = int'(readback.dac_view.a) - target_a;
		dist_b = int'(readback.dac_view.b) - target_b;
		check_count++;
		if (dist_a > 4 * int'(delta_step) || -dist_a > 4 * int'(delta_step)
			|| dist_b > 4 * int'(delta_step) || -dist_b > 4 * int'(delta_step))
		begin
			error_count++;
			$display("u did not settle near the optimum, a=%0d b=%0d",
				readback.dac_view.a, readback.dac_view.b);
		end
	endtask

	// ************************************************************
	// main sequence
	// ************************************************************
	initial
	begin
		int start_errors;
		int wait_sum;
		dac_pair_t mid;
		rst = 1'b1;
		ctrl = '0;
		adc = '0;
		void'($urandom(32'heb4a_83d0));
		build_table();
		wait_sum = 0;
		foreach (table_q[i])
			wait_sum += table_q[i].wait_cycles + 1;
		cycle_limit = 2 * (wait_sum + n_iterations * (iter_last + 1) + reset_cycles + 20);
		mid = {u_init, u_init};

		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;

		foreach (table_q[i])
		begin
			start_errors = error_count;
			run_entry(table_q[i]);
			finish_test($sformatf("entry %0d %s", i, table_q[i].mode.name()), start_errors);
		end

		// optimiser starts from reset state
		plant_a = plant_metric(dac);
		lfsr_m = lfsr_seed;
		u_m = mid;
		start_errors = error_count;
		repeat (n_detailed) run_iteration();
		finish_test("optimiser iterations", start_errors);

		start_errors = error_count;
		repeat (n_iterations - n_detailed) run_iteration();
		check_convergence();
		finish_test("convergence", start_errors);

		start_errors = error_count;
		run_entry(make_entry(system_off, '0, '0, 1, 1'b1, '0, '0, 1'b1));
		run_entry(make_entry(spgd_u, '0, '0, 1, 1'b1, code_word(spgd_u, mid), mid, 1'b0));
		finish_test("return to system_off", start_errors);

		$display("tests %0d, failing tests %0d, checks %0d, errors %0d",
			test_count, failed_tests, check_count, error_count);
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* all.f */
hdl/spgd_pkg.sv
hdl/gpio_box.sv
hdl/spgd_core.sv
hdl/dac_mux.sv
hdl/spgd_top.sv
dv/spgd_top_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module spgd_top_tb -f all.f -Mdir obj_dir -o spgd_sim
./obj_dir/spgd_sim | tee sim.log

if grep -qx "TEST PASSED" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
